// File: logic/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage #(
	parameter int XLEN = pipe_pkg::DEFAULT_XLEN
) (
	input  wire  logic              clk,
	input  wire  logic              rst_n,
	input  wire  pipe_pkg::id_ex_t  id_ex,
	input  wire  pipe_pkg::fwd_a_e  fwd_a,
	input  wire  pipe_pkg::fwd_b_e  fwd_b,
	input  wire  pipe_pkg::fwd_st_e fwd_st,
	input  wire  logic [XLEN-1:0]   mem_wb_data,
	output pipe_pkg::ex_mem_t       ex_mem
);
	import pipe_pkg::*;

	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] st_val;
	logic [XLEN-1:0] alu_out;

	if (XLEN != DEFAULT_XLEN) begin : g_xlen_chk
		$error("exec_stage: XLEN differs from the package data width");
	end

	// operand muxes with the ex_mem forward taken from this stage's own output register
	always_comb begin
		case (fwd_a)
			fa_pc:     op_a = id_ex.pc;
			fa_ex_mem: op_a = ex_mem.result;
			fa_mem_wb: op_a = mem_wb_data;
			default:   op_a = id_ex.rs1_val;
		endcase

		case (fwd_b)
			fb_imm:    op_b = id_ex.imm;
			fb_one:    op_b = XLEN'(1);
			fb_ex_mem: op_b = ex_mem.result;
			fb_mem_wb: op_b = mem_wb_data;
			default:   op_b = id_ex.rs2_val;
		endcase

		// sw data uses the register sources of operand b
		case (fwd_st)
			fs_ex_mem: st_val = ex_mem.result;
			fs_mem_wb: st_val = mem_wb_data;
			default:   st_val = id_ex.rs2_val;
		endcase
	end

	// ALU
	always_comb begin
		case (id_ex.opcode)
			sub:          alu_out = op_a - op_b;
			and_op, andi: alu_out = op_a & op_b;
			or_op, ori:   alu_out = op_a | op_b;
			xor_op, xori: alu_out = op_a ^ op_b;
			// signed compare giving 1 or 0
			slti:         alu_out = ($signed(op_a) < $signed(op_b)) ? XLEN'(1) : '0;
			// shift amount in the low five bits of imm
			sll:          alu_out = op_a << op_b[4:0];
			srl:          alu_out = op_a >> op_b[4:0];
			// add, addi, jal link and sw address
			default:      alu_out = op_a + op_b;
		endcase
	end

	// EX/MEM register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem <= '0;
		end else begin
			ex_mem.valid      <= id_ex.valid;
			ex_mem.wr         <= id_ex.wr;
			ex_mem.is_store   <= id_ex.valid && id_ex.opcode == sw;
			ex_mem.rd         <= id_ex.rd;
			ex_mem.result     <= alu_out;
			ex_mem.store_data <= st_val;
		end
	end

endmodule

`default_nettype wire

// File: logic/forward_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forward_unit #(
	parameter int XLEN = pipe_pkg::DEFAULT_XLEN
) (
	input  wire pipe_pkg::opcode_e   id_ex_opcode,
	input  wire pipe_pkg::reg_addr_t id_ex_rs1,
	input  wire pipe_pkg::reg_addr_t id_ex_rs2,
	input  wire pipe_pkg::reg_addr_t ex_mem_rd,
	input  wire logic                ex_mem_wr,
	input  wire pipe_pkg::reg_addr_t mem_wb_rd,
	input  wire logic                mem_wb_wr,
	output pipe_pkg::fwd_a_e         fwd_a,
	output pipe_pkg::fwd_b_e         fwd_b,
	output pipe_pkg::fwd_st_e        fwd_st
);
	import pipe_pkg::*;

	logic ex_hit_rs1;
	logic ex_hit_rs2;
	logic wb_hit_rs1;
	logic wb_hit_rs2;

	if (XLEN != DEFAULT_XLEN) begin : g_xlen_chk
		$error("forward_unit: XLEN differs from the package data width");
	end

	// EX hazard with the producer one instruction ahead
	assign ex_hit_rs1 = ex_mem_wr && ex_mem_rd != '0 && ex_mem_rd == id_ex_rs1;
	assign ex_hit_rs2 = ex_mem_wr && ex_mem_rd != '0 && ex_mem_rd == id_ex_rs2;
	// MEM hazard with the producer two ahead
	assign wb_hit_rs1 = mem_wb_wr && mem_wb_rd != '0 && mem_wb_rd == id_ex_rs1;
	assign wb_hit_rs2 = mem_wb_wr && mem_wb_rd != '0 && mem_wb_rd == id_ex_rs2;

	always_comb begin
		// jal computes pc + 1
		if (id_ex_opcode == jal)
			fwd_a = fa_pc;
		// newest producer wins when both stages match
		else if (ex_hit_rs1)
			fwd_a = fa_ex_mem;
		else if (wb_hit_rs1)
			fwd_a = fa_mem_wb;
		else
			fwd_a = fa_reg;

		// I-format and sw take the immediate as operand b
		if (uses_imm(id_ex_opcode))
			fwd_b = fb_imm;
		else if (id_ex_opcode == jal)
			fwd_b = fb_one;
		else if (ex_hit_rs2)
			fwd_b = fb_ex_mem;
		else if (wb_hit_rs2)
			fwd_b = fb_mem_wb;
		else
			fwd_b = fb_reg;

		// store data follows rs2 whatever operand b took
		if (ex_hit_rs2)
			fwd_st = fs_ex_mem;
		else if (wb_hit_rs2)
			fwd_st = fs_mem_wb;
		else
			fwd_st = fs_reg;
	end

endmodule

`default_nettype wire

// File: logic/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode #(
	parameter int XLEN = pipe_pkg::DEFAULT_XLEN
) (
	input  wire  logic            clk,
	input  wire  logic            rst_n,
	input  wire  logic            inst_valid,
	input  wire  pipe_pkg::inst_u inst,
	input  wire  logic [XLEN-1:0] pc,
	input  wire  pipe_pkg::wb_t   wb_in,
	output pipe_pkg::id_ex_t      id_ex
);
	import pipe_pkg::*;

	opcode_e         opcode;
	reg_addr_t       rs1;
	reg_addr_t       rs2;
	reg_addr_t       rd;
	logic [XLEN-1:0] rs1_val;
	logic [XLEN-1:0] rs2_val;
	logic [XLEN-1:0] imm_ext;

	if (XLEN != DEFAULT_XLEN) begin : g_xlen_chk
		$error("inst_decode: XLEN differs from the package data width");
	end

	// common fields sit in the same place in both views
	assign opcode = inst.r_fmt.opcode;
	assign rd     = inst.r_fmt.rd;
	assign rs1    = inst.r_fmt.rs1;
	// rs2 only meaningful for R-format and sw
	assign rs2    = inst.r_fmt.rs2;

	// sign-extend the 15 bit immediate
	assign imm_ext = {{(XLEN-15){inst.i_fmt.imm[14]}}, inst.i_fmt.imm};

	reg_file #(
		.XLEN(XLEN)
	) u_reg_file (
		.clk    (clk),
		.rst_n  (rst_n),
		.ra1    (rs1),
		.ra2    (rs2),
		.rd1    (rs1_val),
		.rd2    (rs2_val),
		.wr_port(wb_in)
	);

	// ID/EX register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex <= '0;
		end else begin
			id_ex.valid   <= inst_valid;
			// empty slot never writes back
			id_ex.wr      <= inst_valid && writes_rd(opcode);
			id_ex.opcode  <= opcode;
			id_ex.rs1     <= rs1;
			id_ex.rs2     <= rs2;
			id_ex.rd      <= rd;
			id_ex.pc      <= pc;
			id_ex.rs1_val <= rs1_val;
			id_ex.rs2_val <= rs2_val;
			id_ex.imm     <= imm_ext;
		end
	end

	// environment only presents supported instructions
	a_opcode_defined: assert property (@(posedge clk) disable iff (!rst_n)
		inst_valid |-> op_defined(opcode))
		else $error("inst_decode: undefined opcode %h", opcode);

endmodule

`default_nettype wire

// File: logic/mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage #(
	parameter int XLEN = pipe_pkg::DEFAULT_XLEN
) (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire pipe_pkg::ex_mem_t ex_mem,
	output pipe_pkg::store_t       store,
	output pipe_pkg::wb_t          mem_wb
);
	import pipe_pkg::*;

	if (XLEN != DEFAULT_XLEN) begin : g_xlen_chk
		$error("mem_wb_stage: XLEN differs from the package data width");
	end

	// no data memory, the store is published straight from ex_mem
	always_comb begin
		store.valid = ex_mem.valid && ex_mem.is_store;
		store.addr  = ex_mem.result;
		store.data  = ex_mem.store_data;
	end

	// MEM/WB register, x0 writers dropped here so wb only shows real writes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_wb <= '0;
		end else begin
			mem_wb.valid <= ex_mem.valid && ex_mem.wr && ex_mem.rd != '0;
			mem_wb.rd    <= ex_mem.rd;
			mem_wb.data  <= ex_mem.result;
		end
	end

	// a store entry never turns into a writeback one edge later
	a_store_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
		store.valid |=> !mem_wb.valid)
		else $error("mem_wb_stage: store produced a writeback");

endmodule

`default_nettype wire

// File: logic/pipe_core.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_core #(
	parameter int XLEN = pipe_pkg::DEFAULT_XLEN
) (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire logic            inst_valid,
	input  wire pipe_pkg::inst_u inst,
	input  wire logic [XLEN-1:0] pc,
	output pipe_pkg::wb_t        wb,
	output pipe_pkg::store_t     store
);
	import pipe_pkg::*;

	id_ex_t  id_ex;
	ex_mem_t ex_mem;
	fwd_a_e  fwd_a;
	fwd_b_e  fwd_b;
	fwd_st_e fwd_st;

	// decode, wb feeds the register file write port
	inst_decode #(
		.XLEN(XLEN)
	) u_decode (
		.clk       (clk),
		.rst_n     (rst_n),
		.inst_valid(inst_valid),
		.inst      (inst),
		.pc        (pc),
		.wb_in     (wb),
		.id_ex     (id_ex)
	);

	// mem_wb writer is the wb port itself, valid implies a real write
	forward_unit #(
		.XLEN(XLEN)
	) u_forward (
		.id_ex_opcode(id_ex.opcode),
		.id_ex_rs1   (id_ex.rs1),
		.id_ex_rs2   (id_ex.rs2),
		.ex_mem_rd   (ex_mem.rd),
		.ex_mem_wr   (ex_mem.wr),
		.mem_wb_rd   (wb.rd),
		.mem_wb_wr   (wb.valid),
		.fwd_a       (fwd_a),
		.fwd_b       (fwd_b),
		.fwd_st      (fwd_st)
	);

	exec_stage #(
		.XLEN(XLEN)
	) u_exec (
		.clk        (clk),
		.rst_n      (rst_n),
		.id_ex      (id_ex),
		.fwd_a      (fwd_a),
		.fwd_b      (fwd_b),
		.fwd_st     (fwd_st),
		.mem_wb_data(wb.data),
		.ex_mem     (ex_mem)
	);

	mem_wb_stage #(
		.XLEN(XLEN)
	) u_mem_wb (
		.clk   (clk),
		.rst_n (rst_n),
		.ex_mem(ex_mem),
		.store (store),
		.mem_wb(wb)
	);

endmodule

`default_nettype wire

// File: logic/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	// width the pipeline register structs are built with
	localparam int DEFAULT_XLEN = 32;

	// register index
	typedef logic [4:0] reg_addr_t;

	// funct bits folded into the opcode
	typedef enum logic [6:0] {
		nop    = 7'h00,
		add    = 7'h01,
		sub    = 7'h02,
		and_op = 7'h03,
		or_op  = 7'h04,
		xor_op = 7'h05,
		addi   = 7'h10,
		andi   = 7'h11,
		ori    = 7'h12,
		xori   = 7'h13,
		slti   = 7'h14,
		sll    = 7'h15,
		srl    = 7'h16,
		jal    = 7'h20,
		sw     = 7'h30
	} opcode_e;

	// register-register view, rs2 also read here for sw
	typedef struct packed {
		logic [9:0] unused;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		reg_addr_t  rd;
		opcode_e    opcode;
	} r_fmt_t;

	// immediate view, imm overlaps rs2 and the unused bits
	typedef struct packed {
		logic signed [14:0] imm;
		reg_addr_t          rs1;
		reg_addr_t          rd;
		opcode_e            opcode;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} inst_u;

	// operand a sources, same codes as the forwarding mux select lines
	typedef enum logic [1:0] {
		fa_pc     = 2'b00,
		fa_ex_mem = 2'b01,
		fa_mem_wb = 2'b10,
		fa_reg    = 2'b11
	} fwd_a_e;

	// operand b sources
	typedef enum logic [2:0] {
		fb_imm    = 3'b000,
		fb_one    = 3'b001,
		fb_ex_mem = 3'b010,
		fb_mem_wb = 3'b011,
		fb_reg    = 3'b100
	} fwd_b_e;

	// store data sources
	typedef enum logic [1:0] {
		fs_reg    = 2'b00,
		fs_ex_mem = 2'b01,
		fs_mem_wb = 2'b10
	} fwd_st_e;

	typedef struct packed {
		logic                    valid;
		opcode_e                 opcode;
		reg_addr_t               rs1;
		reg_addr_t               rs2;
		reg_addr_t               rd;
		logic                    wr;
		logic [DEFAULT_XLEN-1:0] pc;
		logic [DEFAULT_XLEN-1:0] rs1_val;
		logic [DEFAULT_XLEN-1:0] rs2_val;
		logic [DEFAULT_XLEN-1:0] imm;
	} id_ex_t;

	typedef struct packed {
		logic                    valid;
		logic                    wr;
		logic                    is_store;
		reg_addr_t               rd;
		logic [DEFAULT_XLEN-1:0] result;
		logic [DEFAULT_XLEN-1:0] store_data;
	} ex_mem_t;

	// mem/wb register, doubles as the writeback port
	typedef struct packed {
		logic                    valid;
		reg_addr_t               rd;
		logic [DEFAULT_XLEN-1:0] data;
	} wb_t;

	typedef struct packed {
		logic                    valid;
		logic [DEFAULT_XLEN-1:0] addr;
		logic [DEFAULT_XLEN-1:0] data;
	} store_t;

	// second alu operand is the immediate
	function automatic logic uses_imm(opcode_e op);
		return op inside {addi, andi, ori, xori, slti, sll, srl, sw};
	endfunction

	// instruction produces a register result
	function automatic logic writes_rd(opcode_e op);
		return op inside {add, sub, and_op, or_op, xor_op,
			addi, andi, ori, xori, slti, sll, srl, jal};
	endfunction

	function automatic logic op_defined(opcode_e op);
		return writes_rd(op) || op == sw || op == nop;
	endfunction

endpackage

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
	parameter int XLEN = pipe_pkg::DEFAULT_XLEN
) (
	input  wire  logic              clk,
	input  wire  logic              rst_n,
	input  wire  pipe_pkg::reg_addr_t ra1,
	input  wire  pipe_pkg::reg_addr_t ra2,
	output logic [XLEN-1:0]         rd1,
	output logic [XLEN-1:0]         rd2,
	input  wire  pipe_pkg::wb_t     wr_port
);
	import pipe_pkg::*;

	logic [XLEN-1:0] regs [32];
	logic            hit1;
	logic            hit2;

	if (XLEN != DEFAULT_XLEN) begin : g_xlen_chk
		$error("reg_file: XLEN differs from the package data width");
	end

	// write-through when the writeback targets the register being read
	assign hit1 = ra1 != '0 && wr_port.valid && wr_port.rd == ra1;
	assign hit2 = ra2 != '0 && wr_port.valid && wr_port.rd == ra2;

	// the value written at the next edge is already returned now
	assign rd1 = hit1 ? wr_port.data : regs[ra1];
	assign rd2 = hit2 ? wr_port.data : regs[ra2];

	// x0 is never written and keeps its reset value of zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_port.valid && wr_port.rd != '0) begin
			regs[wr_port.rd] <= wr_port.data;
		end
	end

endmodule

`default_nettype wire

// File: project.f
logic/pipe_pkg.sv
logic/reg_file.sv
logic/inst_decode.sv
logic/forward_unit.sv
logic/exec_stage.sv
logic/mem_wb_stage.sv
logic/pipe_core.sv
verification/pipe_checker.sv
verification/pipe_core_tb.sv

// File: verification/pipe_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_checker (
	input  wire logic             clk,
	input  wire logic             rst_n,
	input  wire logic             inst_valid,
	input  wire pipe_pkg::inst_u  inst,
	input  wire logic [31:0]      pc,
	input  wire pipe_pkg::wb_t    wb,
	input  wire pipe_pkg::store_t store,
	output int                    err_count,
	output int                    check_count,
	output int                    pending
);
	import pipe_pkg::*;

	// architectural state, updated in program order
	logic [31:0] model_regs [32];
	wb_t         exp_wb [$];
	store_t      exp_st [$];

	initial begin
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		err_count = 0;
		check_count = 0;
		pending = 0;
	end

	// one instruction through the sequential model
	task automatic step_model(input inst_u w, input logic [31:0] ipc);
		opcode_e     op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] res;
		logic        writes;
		wb_t         e;
		store_t      s;
		op = w.r_fmt.opcode;
		a = model_regs[w.r_fmt.rs1];
		b = model_regs[w.r_fmt.rs2];
		imm = {{17{w.i_fmt.imm[14]}}, w.i_fmt.imm};
		writes = 1'b1;
		res = '0;
		case (op)
			add:    res = a + b;
			sub:    res = a - b;
			and_op: res = a & b;
			or_op:  res = a | b;
			xor_op: res = a ^ b;
			addi:   res = a + imm;
			andi:   res = a & imm;
			ori:    res = a | imm;
			xori:   res = a ^ imm;
			slti:   res = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
			sll:    res = a << imm[4:0];
			srl:    res = a >> imm[4:0];
			// link value only
			jal:    res = ipc + 32'd1;
			sw: begin
				writes = 1'b0;
				s.valid = 1'b1;
				s.addr = a + imm;
				s.data = b;
				exp_st.push_back(s);
			end
			default: writes = 1'b0;
		endcase
		// x0 writes vanish and produce no wb
		if (writes && w.r_fmt.rd != '0) begin
			model_regs[w.r_fmt.rd] = res;
			e.valid = 1'b1;
			e.rd = w.r_fmt.rd;
			e.data = res;
			exp_wb.push_back(e);
		end
	endtask

	// inputs are stable at the rising edge
	always @(posedge clk) begin
		if (rst_n && inst_valid)
			step_model(inst, pc);
	end

	task automatic compare_wb();
		wb_t e;
		if (exp_wb.size() == 0) begin
			$display("writeback to x%0d at %0t arrived with no result pending", wb.rd, $time);
			err_count++;
		end else begin
			e = exp_wb.pop_front();
			check_count++;
			if (wb.rd !== e.rd || wb.data !== e.data) begin
				$display("FAIL %0t: wb rd %0d data %h, expected rd %0d data %h",
					$time, wb.rd, wb.data, e.rd, e.data);
				err_count++;
			end
		end
	endtask

	task automatic compare_store();
		store_t s;
		if (exp_st.size() == 0) begin
			$display("store to %h at %0t arrived with no store pending", store.addr, $time);
			err_count++;
		end else begin
			s = exp_st.pop_front();
			check_count++;
			if (store.addr !== s.addr || store.data !== s.data) begin
				$display("FAIL %0t: store addr %h data %h, expected addr %h data %h",
					$time, store.addr, store.data, s.addr, s.data);
				err_count++;
			end
		end
	endtask

	// outputs settle after the rising edge, look at them mid-cycle
	always @(negedge clk) begin
		if (rst_n) begin
			if (wb.valid)
				compare_wb();
			if (store.valid)
				compare_store();
		end
		pending = exp_wb.size() + exp_st.size();
	end

endmodule

`default_nettype wire

// File: verification/pipe_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_core_tb;
	import pipe_pkg::*;

	logic        clk;
	logic        rst_n;
	logic        inst_valid;
	inst_u       inst;
	logic [31:0] pc;
	wb_t         wb;
	store_t      store;
	int          err_count;
	int          check_count;
	int          pending;
	logic [31:0] lcg_state;
	logic [31:0] pc_next;
	int          test_count;
	int          drain_fail;
	int          err_before;

	pipe_core #(
		.XLEN(32)
	) UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.inst_valid(inst_valid),
		.inst      (inst),
		.pc        (pc),
		.wb        (wb),
		.store     (store)
	);

	pipe_checker u_checker (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.pc         (pc),
		.wb         (wb),
		.store      (store),
		.err_count  (err_count),
		.check_count(check_count),
		.pending    (pending)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// hard stop in case the sequence itself stalls
	initial begin
		#200000;
		$display("simulation watchdog expired before the tests completed");
		$display("ERRORS FOUND");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// upper bits of the lcg are the better ones
	function automatic int below(input int n);
		logic [31:0] t;
		t = next_rand();
		return int'((t >> 8) % n);
	endfunction

	// random 15 bit immediate including its sign bit
	function automatic logic [14:0] rand_imm();
		logic [31:0] t;
		t = next_rand();
		return t[30:16];
	endfunction

	function automatic reg_addr_t any_reg();
		return reg_addr_t'(below(32));
	endfunction

	function automatic reg_addr_t live_reg();
		return reg_addr_t'(below(31) + 1);
	endfunction

	function automatic opcode_e r_op();
		case (below(5))
			0:       return add;
			1:       return sub;
			2:       return and_op;
			3:       return or_op;
			default: return xor_op;
		endcase
	endfunction

	function automatic opcode_e i_op();
		case (below(7))
			0:       return addi;
			1:       return andi;
			2:       return ori;
			3:       return xori;
			4:       return slti;
			5:       return sll;
			default: return srl;
		endcase
	endfunction

	function automatic inst_u r_word(input opcode_e op, input reg_addr_t rd,
		input reg_addr_t rs1, input reg_addr_t rs2);
		inst_u w;
		w = '0;
		w.r_fmt.opcode = op;
		w.r_fmt.rd = rd;
		w.r_fmt.rs1 = rs1;
		w.r_fmt.rs2 = rs2;
		return w;
	endfunction

	function automatic inst_u i_word(input opcode_e op, input reg_addr_t rd,
		input reg_addr_t rs1, input logic [14:0] imm);
		inst_u w;
		w = '0;
		w.i_fmt.opcode = op;
		w.i_fmt.rd = rd;
		w.i_fmt.rs1 = rs1;
		w.i_fmt.imm = imm;
		return w;
	endfunction

	// rs2 overwrites the low five offset bits that both views share
	function automatic inst_u store_word(input reg_addr_t rs1, input reg_addr_t rs2,
		input logic [14:0] imm);
		inst_u w;
		w = i_word(sw, '0, rs1, imm);
		w.r_fmt.rs2 = rs2;
		return w;
	endfunction

	task automatic issue(input inst_u w);
		@(negedge clk);
		inst_valid = 1'b1;
		inst = w;
		pc = pc_next;
		pc_next = pc_next + 32'd1;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			inst_valid = 1'b0;
			inst = r_word(nop, '0, '0, '0);
		end
	endtask

	// let the pipe empty and then report the test
	task automatic finish_test(input string name);
		int waited;
		idle(1);
		waited = 0;
		@(posedge clk);
		while (pending != 0 && waited < 64) begin
			@(posedge clk);
			waited++;
		end
		test_count++;
		if (pending != 0) begin
			$display("test %0d %s: %0d expected results never came out of the pipe",
				test_count, name, pending);
			drain_fail++;
		end else if (err_count != err_before) begin
			$display("test %0d %s: %0d mismatches", test_count, name, err_count - err_before);
		end else begin
			$display("test %0d %s: all results matched", test_count, name);
		end
		err_before = err_count;
	endtask

	initial begin
		reg_addr_t c;
		reg_addr_t nd;
		reg_addr_t w;
		int        k;
		rst_n = 1'b0;
		inst_valid = 1'b0;
		inst = r_word(nop, '0, '0, '0);
		pc = '0;
		pc_next = '0;
		lcg_state = 32'd80;
		test_count = 0;
		drain_fail = 0;
		err_before = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// seed every register, then R-format ops spaced past any hazard
		for (int r = 1; r < 32; r++)
			issue(i_word(addi, reg_addr_t'(r), '0, rand_imm()));
		idle(3);
		repeat (20) begin
			issue(r_word(r_op(), any_reg(), any_reg(), any_reg()));
			idle(3);
		end
		finish_test("register file path");

		// distance 1 chains where the same rd twice in a row makes ex_mem and mem_wb both match
		c = live_reg();
		repeat (24) begin
			nd = (below(2) == 0) ? c : live_reg();
			issue(r_word(r_op(), nd, c, (below(2) == 0) ? c : any_reg()));
			c = nd;
		end
		finish_test("distance 1 chains");

		// gap of one or two slots gives distance 2 or 3
		repeat (20) begin
			w = live_reg();
			issue(i_word(addi, w, any_reg(), rand_imm()));
			idle(1 + below(2));
			issue(r_word(r_op(), live_reg(), w, (below(2) == 0) ? w : any_reg()));
		end
		finish_test("distance 2 and 3");

		repeat (40)
			issue(i_word(i_op(), any_reg(), any_reg(), rand_imm()));
		// shift extremes and a negative compare
		issue(i_word(sll, live_reg(), live_reg(), 15'd0));
		issue(i_word(srl, live_reg(), live_reg(), 15'd31));
		issue(i_word(slti, live_reg(), live_reg(), 15'h7fff));
		finish_test("I-format immediates");

		repeat (8) begin
			issue(i_word(jal, any_reg(), any_reg(), rand_imm()));
			w = live_reg();
			issue(r_word(r_op(), w, any_reg(), any_reg()));
			idle(below(3));
			issue(store_word(any_reg(), w, rand_imm()));
		end
		finish_test("jal link and sw forwarding");

		// small register window keeps hazards frequent and x0 shows up often
		repeat (300) begin
			if (below(4) == 0)
				idle(1 + below(3));
			nd = (below(6) == 0) ? '0 : reg_addr_t'(below(8));
			k = below(8);
			if (k < 3)
				issue(r_word(r_op(), nd, reg_addr_t'(below(8)), reg_addr_t'(below(8))));
			else if (k < 6)
				issue(i_word(i_op(), nd, reg_addr_t'(below(8)), rand_imm()));
			else if (k == 6)
				issue(i_word(jal, nd, '0, '0));
			else
				issue(store_word(reg_addr_t'(below(8)), reg_addr_t'(below(8)), rand_imm()));
		end
		finish_test("random mix");

		$display("tests %0d, checks %0d, mismatches %0d, undrained tests %0d",
			test_count, check_count, err_count, drain_fail);
		if (err_count == 0 && drain_fail == 0 && check_count > 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire
